// ==== rtl/calc_io_pkg.sv ====
`default_nettype none

package calc_io_pkg;

    // Key number, column * 4 + row
    typedef logic [3:0] key_code_t;

    // Register byte offsets
    localparam logic [3:0] reg_key  = 4'h0;
    localparam logic [3:0] reg_disp = 4'h4;
    localparam logic [3:0] reg_stat = 4'h8;

    // AXI response codes
    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

    // Controller command view of a display word
    typedef struct packed {
        logic        kind;
        logic [22:0] pad;
        logic [7:0]  opcode;
    } disp_cmd_t;

    // Pixel view, rgb565 sent high byte first
    typedef struct packed {
        logic        kind;
        logic [14:0] pad;
        logic [15:0] rgb565;
    } disp_pix_t;

    // Bit 31 is shared: 0 command, 1 pixel
    typedef union packed {
        disp_cmd_t cmd;
        disp_pix_t pix;
    } disp_word_u;

endpackage

`default_nettype wire

// ==== rtl/keypad_scanner.sv ====
`timescale 1ns/1ps
`default_nettype none

module keypad_scanner import calc_io_pkg::*; #(
    parameter int scan_div = 8
) (
    input  logic       clk,
    input  logic       rst,
    input  logic [3:0] row,
    output logic [3:0] column,
    output logic       key_valid,
    output key_code_t  key_code
);

    localparam int cnt_w = (scan_div > 1) ? $clog2(scan_div) : 1;
    localparam logic [cnt_w-1:0] cnt_last = cnt_w'(scan_div - 1);

    logic [cnt_w-1:0] div_cnt;
    logic             sample;
    logic             hit;
    logic [1:0]       row_idx;
    logic [1:0]       col_idx;
    logic             pressed_this;
    logic             pressed_last;

    // Rows are only looked at on the last cycle of a column
    assign sample = (div_cnt == cnt_last);
    assign hit    = |row;

    // Lowest active row wins
    always_comb begin
        row_idx = 2'd0;
        for (int i = 3; i >= 0; i--) begin
            if (row[i]) begin
                row_idx = 2'(i);
            end
        end
    end

    always_comb begin
        col_idx = 2'd0;
        for (int i = 0; i < 4; i++) begin
            if (column[i]) begin
                col_idx = 2'(i);
            end
        end
    end

    // Column strobe
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            div_cnt <= '0;
            column  <= 4'b0001;
        end else if (sample) begin
            div_cnt <= '0;
            column  <= {column[2:0], column[3]};
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // New press only after a scan with nothing held
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pressed_this <= 1'b0;
            pressed_last <= 1'b0;
            key_valid    <= 1'b0;
        end else begin
            key_valid <= sample && hit && !pressed_last;
            if (sample && column[3]) begin
                pressed_last <= pressed_this || hit;
                pressed_this <= 1'b0;
            end else if (sample && hit) begin
                pressed_this <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sample && hit) begin
            key_code <= {col_idx, row_idx};
        end
    end

    a_column_onehot: assert property (@(posedge clk) disable iff (rst) $onehot(column));

endmodule

`default_nettype wire

// ==== rtl/lcd_write_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module lcd_write_engine import calc_io_pkg::*; #(
    parameter int wr_half = 2
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       disp_valid,
    input  disp_word_u disp_word,
    output logic       disp_ready,
    output logic       lcd_csx,
    output logic       lcd_dcx,
    output logic       lcd_wrx,
    output logic [7:0] lcd_data
);

    localparam int ph_w = (wr_half > 1) ? $clog2(wr_half) : 1;
    localparam logic [ph_w-1:0] ph_last = ph_w'(wr_half - 1);

    localparam logic [1:0] st_idle   = 2'd0;
    localparam logic [1:0] st_low    = 2'd1;
    localparam logic [1:0] st_high   = 2'd2;
    localparam logic [1:0] st_finish = 2'd3;

    logic [1:0]      state;
    logic [ph_w-1:0] phase;
    logic            byte_idx;
    disp_word_u      word_q;
    logic            accept;
    logic            last_byte;

    assign disp_ready = (state == st_idle);
    assign accept     = disp_valid && disp_ready;
    // Commands carry one byte, pixels two
    assign last_byte  = !word_q.pix.kind || byte_idx;

    always_ff @(posedge clk) begin
        if (accept) begin
            word_q <= disp_word;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= st_idle;
            phase    <= '0;
            byte_idx <= 1'b0;
            lcd_csx  <= 1'b1;
            lcd_wrx  <= 1'b1;
            lcd_dcx  <= 1'b0;
            lcd_data <= 8'h00;
        end else begin
            case (state)
                st_idle: begin
                    if (accept) begin
                        state    <= st_low;
                        phase    <= '0;
                        byte_idx <= 1'b0;
                        lcd_csx  <= 1'b0;
                        lcd_wrx  <= 1'b0;
                        lcd_dcx  <= disp_word.cmd.kind;
                        lcd_data <= disp_word.cmd.kind ? disp_word.pix.rgb565[15:8]
                                                       : disp_word.cmd.opcode;
                    end
                end
                st_low: begin
                    if (phase == ph_last) begin
                        phase   <= '0;
                        lcd_wrx <= 1'b1;
                        state   <= st_high;
                    end else begin
                        phase <= phase + 1'b1;
                    end
                end
                st_high: begin
                    if (phase != ph_last) begin
                        phase <= phase + 1'b1;
                    end else if (last_byte) begin
                        phase <= '0;
                        state <= st_finish;
                    end else begin
                        // Low byte of the pixel
                        phase    <= '0;
                        byte_idx <= 1'b1;
                        lcd_wrx  <= 1'b0;
                        lcd_data <= word_q.pix.rgb565[7:0];
                        state    <= st_low;
                    end
                end
                default: begin
                    lcd_csx <= 1'b1;
                    state   <= st_idle;
                end
            endcase
        end
    end

    a_wrx_in_cs: assert property (@(posedge clk) disable iff (rst) !lcd_wrx |-> !lcd_csx);

    a_data_stable: assert property (@(posedge clk) disable iff (rst)
        (!lcd_wrx && !$past(lcd_wrx)) |-> $stable(lcd_data));

endmodule

`default_nettype wire

// ==== rtl/mmio_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module mmio_ctrl import calc_io_pkg::*; (
    input  logic        clk,
    input  logic        rst,

    // AXI4-Lite slave
    input  logic [3:0]  awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic        wvalid,
    output logic        wready,
    output logic [1:0]  bresp,
    output logic        bvalid,
    input  logic        bready,
    input  logic [3:0]  araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  logic        rready,

    // Keypad scanner
    input  logic        key_valid,
    input  key_code_t   key_code,

    // Display engine
    input  logic        disp_ready,
    output logic        disp_valid,
    output disp_word_u  disp_word
);

    logic        wr_is_disp;
    logic        wr_mapped;
    logic        rd_mapped;
    logic        wr_go;
    logic        wr_hs;
    logic        ar_hs;
    logic        rd_key;
    logic        rd_stat;
    logic        key_pend;
    logic        key_ovr;
    key_code_t   key_q;
    logic [31:0] rd_data;

    assign wr_is_disp = (awaddr == reg_disp);
    assign wr_mapped  = (awaddr == reg_key) || wr_is_disp || (awaddr == reg_stat);
    assign rd_mapped  = (araddr == reg_key) || (araddr == reg_disp) || (araddr == reg_stat);

    // Display writes wait here until the engine is free
    assign wr_go = awvalid && wvalid && !awready && !bvalid && !disp_valid &&
                   (!wr_is_disp || disp_ready);
    assign wr_hs = awvalid && awready && wvalid && wready;

    assign ar_hs   = arvalid && arready;
    assign rd_key  = ar_hs && (araddr == reg_key);
    assign rd_stat = ar_hs && (araddr == reg_stat);

    always_comb begin
        case (araddr)
            reg_key:  rd_data = {key_pend, 27'd0, key_q};
            reg_stat: rd_data = {30'd0, key_ovr, !disp_ready};
            default:  rd_data = 32'd0;
        endcase
    end

    // Write channel
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            awready    <= 1'b0;
            wready     <= 1'b0;
            bvalid     <= 1'b0;
            disp_valid <= 1'b0;
        end else begin
            awready <= wr_go;
            wready  <= wr_go;
            if (wr_hs) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            if (wr_hs && wr_is_disp) begin
                disp_valid <= 1'b1;
            end else if (disp_ready) begin
                disp_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_hs) begin
            bresp <= wr_mapped ? resp_okay : resp_slverr;
        end
        if (wr_hs && wr_is_disp) begin
            disp_word <= wdata;
        end
    end

    // Read channel
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            arready <= arvalid && !arready && !rvalid;
            if (ar_hs) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ar_hs) begin
            rdata <= rd_data;
            rresp <= rd_mapped ? resp_okay : resp_slverr;
        end
    end

    // Pending key and overrun, both clear on read
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            key_pend <= 1'b0;
            key_ovr  <= 1'b0;
        end else begin
            if (key_valid) begin
                key_pend <= 1'b1;
            end else if (rd_key) begin
                key_pend <= 1'b0;
            end
            // Old key not yet read back gets replaced
            if (key_valid && key_pend && !rd_key) begin
                key_ovr <= 1'b1;
            end else if (rd_stat) begin
                key_ovr <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (key_valid) begin
            key_q <= key_code;
        end
    end

    a_bvalid_hold: assert property (@(posedge clk) disable iff (rst)
        (bvalid && !bready) |=> bvalid);

    a_rvalid_hold: assert property (@(posedge clk) disable iff (rst)
        (rvalid && !rready) |=> rvalid);

endmodule

`default_nettype wire

// ==== rtl/calc_io_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module calc_io_top import calc_io_pkg::*; #(
    parameter int scan_div = 8,
    parameter int wr_half  = 2
) (
    input  logic        clk,
    input  logic        rst,

    // AXI4-Lite slave
    input  logic [3:0]  awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic        wvalid,
    output logic        wready,
    output logic [1:0]  bresp,
    output logic        bvalid,
    input  logic        bready,
    input  logic [3:0]  araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  logic        rready,

    // Keypad matrix
    output logic [3:0]  column,
    input  logic [3:0]  row,

    // 8080 LCD bus
    output logic        lcd_csx,
    output logic        lcd_dcx,
    output logic        lcd_wrx,
    output logic [7:0]  lcd_data
);

    logic       key_valid;
    key_code_t  key_code;
    logic       disp_valid;
    logic       disp_ready;
    disp_word_u disp_word;

    mmio_ctrl i_ctrl (
        .clk        (clk),
        .rst        (rst),
        .awaddr     (awaddr),
        .awvalid    (awvalid),
        .awready    (awready),
        .wdata      (wdata),
        .wvalid     (wvalid),
        .wready     (wready),
        .bresp      (bresp),
        .bvalid     (bvalid),
        .bready     (bready),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .rdata      (rdata),
        .rresp      (rresp),
        .rvalid     (rvalid),
        .rready     (rready),
        .key_valid  (key_valid),
        .key_code   (key_code),
        .disp_ready (disp_ready),
        .disp_valid (disp_valid),
        .disp_word  (disp_word)
    );

    keypad_scanner #(
        .scan_div (scan_div)
    ) i_scanner (
        .clk       (clk),
        .rst       (rst),
        .row       (row),
        .column    (column),
        .key_valid (key_valid),
        .key_code  (key_code)
    );

    lcd_write_engine #(
        .wr_half (wr_half)
    ) i_lcd (
        .clk        (clk),
        .rst        (rst),
        .disp_valid (disp_valid),
        .disp_word  (disp_word),
        .disp_ready (disp_ready),
        .lcd_csx    (lcd_csx),
        .lcd_dcx    (lcd_dcx),
        .lcd_wrx    (lcd_wrx),
        .lcd_data   (lcd_data)
    );

endmodule

`default_nettype wire

// ==== bench/io_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module io_checker (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] rdata,
    input  logic [1:0]  rresp,
    input  logic        rvalid,
    input  logic        rready,
    input  logic [1:0]  bresp,
    input  logic        bvalid,
    input  logic        bready,
    input  logic        lcd_csx,
    input  logic        lcd_dcx,
    input  logic        lcd_wrx,
    input  logic [7:0]  lcd_data
);

    // Expected AXI reads, in issue order
    string       rd_name[$];
    logic [31:0] rd_exp[$];
    logic [31:0] rd_mask[$];
    logic [1:0]  rd_resp[$];
    bit          rd_poll[$];

    // Expected write responses
    string       wr_name[$];
    logic [1:0]  wr_resp[$];

    // Expected LCD bytes as {dcx, data}
    string       lcd_name[$];
    logic [8:0]  lcd_exp[$];

    logic        wrx_q;

    int read_errs  = 0;
    int write_errs = 0;
    int lcd_errs   = 0;

    // A poll entry only checks its data once the valid flag shows up
    function void expect_read(input string name, input logic [31:0] data,
                              input logic [31:0] mask, input logic [1:0] resp, input bit poll);
        rd_name.push_back(name);
        rd_exp.push_back(data);
        rd_mask.push_back(mask);
        rd_resp.push_back(resp);
        rd_poll.push_back(poll);
    endfunction

    function void expect_write(input string name, input logic [1:0] resp);
        wr_name.push_back(name);
        wr_resp.push_back(resp);
    endfunction

    function void expect_lcd(input string name, input logic [8:0] pair);
        lcd_name.push_back(name);
        lcd_exp.push_back(pair);
    endfunction

    function int lcd_pending();
        return lcd_exp.size();
    endfunction

    // Read channel
    always @(posedge clk) begin
        string       name;
        logic [31:0] exp;
        logic [31:0] mask;
        logic [1:0]  resp;
        bit          poll;
        if (!rst && rvalid && rready) begin
            if (rd_exp.size() == 0) begin
                $display("Read data %h returned while no read was expected", rdata);
                read_errs++;
            end else begin
                name = rd_name.pop_front();
                exp  = rd_exp.pop_front();
                mask = rd_mask.pop_front();
                resp = rd_resp.pop_front();
                poll = rd_poll.pop_front();
                if (rresp !== resp) begin
                    $display("[FAIL] %s: expected rresp %0d, actual %0d", name, resp, rresp);
                    read_errs++;
                end
                if (!(poll && !rdata[31]) && ((rdata & mask) !== (exp & mask))) begin
                    $display("[FAIL] %s: expected %h, actual %h", name, exp & mask,
                             rdata & mask);
                    read_errs++;
                end
            end
        end
    end

    // Write response channel
    always @(posedge clk) begin
        string      name;
        logic [1:0] resp;
        if (!rst && bvalid && bready) begin
            if (wr_resp.size() == 0) begin
                $display("Write response returned while no write was expected");
                write_errs++;
            end else begin
                name = wr_name.pop_front();
                resp = wr_resp.pop_front();
                if (bresp !== resp) begin
                    $display("[FAIL] %s: expected bresp %0d, actual %0d", name, resp, bresp);
                    write_errs++;
                end
            end
        end
    end

    // LCD bus, one byte per rising edge of the write strobe
    always @(posedge clk or posedge rst) begin
        string      name;
        logic [8:0] exp;
        logic [8:0] act;
        if (rst) begin
            wrx_q <= 1'b1;
        end else begin
            wrx_q <= lcd_wrx;
            if (lcd_wrx && !wrx_q) begin
                act = {lcd_dcx, lcd_data};
                if (lcd_csx) begin
                    $display("LCD write strobe seen while chip select was high");
                    lcd_errs++;
                end
                if (lcd_exp.size() == 0) begin
                    $display("LCD byte %h with dcx %b written with no display word pending",
                             lcd_data, lcd_dcx);
                    lcd_errs++;
                end else begin
                    name = lcd_name.pop_front();
                    exp  = lcd_exp.pop_front();
                    if (act !== exp) begin
                        $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
                        lcd_errs++;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== bench/tb_calc_io.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_calc_io import calc_io_pkg::*; ();

    localparam int scan_div = 8;
    localparam int wr_half  = 2;
    // 16 key presses plus six further test steps
    localparam int n_tests      = 22;
    localparam int limit_cycles = n_tests * (8 * 4 * scan_div + 40 * 4 * wr_half);

    logic        clk;
    logic        rst;
    logic [3:0]  awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [3:0]  araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;
    logic [3:0]  column;
    logic [3:0]  row;
    logic        lcd_csx;
    logic        lcd_dcx;
    logic        lcd_wrx;
    logic [7:0]  lcd_data;

    // Keypad model state
    logic        key_held;
    logic [1:0]  key_col;
    logic [1:0]  key_row;
    logic        ready_mode;
    logic [31:0] rng;

    // Held key closes its row only while its column is strobed
    assign row = (key_held && column[key_col]) ? (4'b0001 << key_row) : 4'b0000;

    calc_io_top #(
        .scan_div (scan_div),
        .wr_half  (wr_half)
    ) i_dut (
        .clk (clk), .rst (rst),
        .awaddr (awaddr), .awvalid (awvalid), .awready (awready),
        .wdata (wdata), .wvalid (wvalid), .wready (wready),
        .bresp (bresp), .bvalid (bvalid), .bready (bready),
        .araddr (araddr), .arvalid (arvalid), .arready (arready),
        .rdata (rdata), .rresp (rresp), .rvalid (rvalid), .rready (rready),
        .column (column), .row (row),
        .lcd_csx (lcd_csx), .lcd_dcx (lcd_dcx), .lcd_wrx (lcd_wrx), .lcd_data (lcd_data)
    );

    io_checker i_chk (
        .clk (clk), .rst (rst),
        .rdata (rdata), .rresp (rresp), .rvalid (rvalid), .rready (rready),
        .bresp (bresp), .bvalid (bvalid), .bready (bready),
        .lcd_csx (lcd_csx), .lcd_dcx (lcd_dcx), .lcd_wrx (lcd_wrx), .lcd_data (lcd_data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] next_random();
        rng ^= rng << 13;
        rng ^= rng >> 17;
        rng ^= rng << 5;
        return rng;
    endfunction

    function automatic logic pick_ready();
        logic [31:0] r;
        r = next_random();
        return ready_mode ? (r[1:0] != 2'b00) : 1'b1;
    endfunction

    function automatic key_code_t key_code_for(input logic [1:0] col, input logic [1:0] r);
        return key_code_t'(col * 4 + r);
    endfunction

    // Expected LCD bytes of a display word, each as {dcx, data}
    function automatic int lcd_bytes(input disp_word_u w, output logic [8:0] first,
                                     output logic [8:0] second);
        if (w.cmd.kind) begin
            first  = {1'b1, w.pix.rgb565[15:8]};
            second = {1'b1, w.pix.rgb565[7:0]};
            return 2;
        end else begin
            first  = {1'b0, w.cmd.opcode};
            second = 9'h000;
            return 1;
        end
    endfunction

    task automatic wait_scans(input int n);
        repeat (n * 4 * scan_div) @(negedge clk);
    endtask

    task automatic axi_write(input logic [3:0] addr, input logic [31:0] data);
        logic done;
        @(negedge clk);
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        @(negedge clk);
        while (!(awready && wready)) @(negedge clk);
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        done    = 1'b0;
        while (!done) begin
            if (bvalid) begin
                bready = pick_ready();
                done   = bready;
            end
            @(negedge clk);
        end
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [3:0] addr, output logic [31:0] data);
        logic done;
        @(negedge clk);
        araddr  = addr;
        arvalid = 1'b1;
        @(negedge clk);
        while (!arready) @(negedge clk);
        @(negedge clk);
        arvalid = 1'b0;
        done    = 1'b0;
        data    = '0;
        while (!done) begin
            if (rvalid) begin
                rready = pick_ready();
                done   = rready;
                data   = rdata;
            end
            @(negedge clk);
        end
        rready = 1'b0;
    endtask

    task automatic hold_key(input logic [1:0] col, input logic [1:0] r);
        @(negedge clk);
        key_col  = col;
        key_row  = r;
        key_held = 1'b1;
    endtask

    task automatic release_key();
        @(negedge clk);
        key_held = 1'b0;
    endtask

    // Poll reg_key until the valid flag is set
    task automatic poll_key(input string name, input key_code_t code);
        logic [31:0] d;
        d = '0;
        while (!d[31]) begin
            i_chk.expect_read(name, {1'b1, 27'd0, code}, 32'hffff_ffff, resp_okay, 1'b1);
            axi_read(reg_key, d);
        end
    endtask

    task automatic check_read(input string name, input logic [3:0] addr,
                              input logic [31:0] exp, input logic [31:0] mask);
        logic [31:0] d;
        i_chk.expect_read(name, exp, mask, resp_okay, 1'b0);
        axi_read(addr, d);
    endtask

    task automatic send_disp(input string name, input disp_word_u w);
        logic [8:0] p0;
        logic [8:0] p1;
        int         n;
        n = lcd_bytes(w, p0, p1);
        i_chk.expect_lcd(name, p0);
        if (n == 2) begin
            i_chk.expect_lcd(name, p1);
        end
        i_chk.expect_write(name, resp_okay);
        axi_write(reg_disp, w);
    endtask

    task automatic drain_lcd();
        while (i_chk.lcd_pending() != 0) @(negedge clk);
    endtask

    initial begin
        repeat (limit_cycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles", limit_cycles);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        int          total;
        logic [31:0] d;
        disp_word_u  w;
        rst = 1'b1;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        key_held = 1'b0;
        key_col = '0;
        key_row = '0;
        ready_mode = 1'b0;
        rng = 32'd68455;
        repeat (3) @(negedge clk);
        rst = 1'b0;

        // Every key in turn
        ready_mode = 1'b1;
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                hold_key(2'(c), 2'(r));
                poll_key("key_each", key_code_for(2'(c), 2'(r)));
                release_key();
                check_read("key_each_clear", reg_key, 32'h0, 32'h8000_0000);
                wait_scans(2);
            end
        end

        // Long hold gives a single report
        hold_key(2'd2, 2'd1);
        poll_key("key_hold", key_code_for(2'd2, 2'd1));
        wait_scans(6);
        check_read("key_hold_once", reg_key, 32'h0, 32'h8000_0000);
        release_key();
        wait_scans(2);

        // Two presses without a read
        hold_key(2'd1, 2'd3);
        wait_scans(2);
        release_key();
        wait_scans(2);
        hold_key(2'd3, 2'd0);
        wait_scans(2);
        release_key();
        wait_scans(2);
        check_read("overrun_set", reg_stat, 32'h2, 32'h3);
        check_read("overrun_key", reg_key, {1'b1, 27'd0, key_code_for(2'd3, 2'd0)}, '1);
        check_read("overrun_clear", reg_stat, 32'h0, 32'h3);
        check_read("overrun_key_clear", reg_key, 32'h0, 32'h8000_0000);

        // Random display words
        ready_mode = 1'b0;
        for (int i = 0; i < 12; i++) begin
            w = next_random();
            send_disp("disp_random", w);
        end
        drain_lcd();

        // Busy while a pixel is in flight, then back-to-back with random bready
        w = next_random();
        w.pix.kind = 1'b1;
        send_disp("disp_busy", w);
        check_read("busy_stat", reg_stat, 32'h1, 32'h3);
        ready_mode = 1'b1;
        for (int i = 0; i < 10; i++) begin
            w = next_random();
            send_disp("disp_b2b", w);
        end
        drain_lcd();

        // Unmapped offset
        i_chk.expect_write("unmapped_write", resp_slverr);
        axi_write(4'hc, 32'h8000_a5c3);
        i_chk.expect_read("unmapped_read", 32'h0, '1, resp_slverr, 1'b0);
        axi_read(4'hc, d);
        repeat (8 * 4 * wr_half) @(negedge clk);

        total = i_chk.read_errs + i_chk.write_errs + i_chk.lcd_errs;
        $display("Errors: read %0d, write %0d, lcd %0d", i_chk.read_errs,
                 i_chk.write_errs, i_chk.lcd_errs);
        if (total == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
rtl/calc_io_pkg.sv
rtl/keypad_scanner.sv
rtl/lcd_write_engine.sv
rtl/mmio_ctrl.sv
rtl/calc_io_top.sv
bench/io_checker.sv
bench/tb_calc_io.sv

// ==== Makefile ====
# Verilator build and run of the calculator I/O testbench

VERILATOR ?= verilator
TOP       ?= tb_calc_io
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?=
JOBS      ?= 0

SIM := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) --binary --assert -j $(JOBS) --top-module $(TOP) \
		-Mdir $(OBJ_DIR) -f $(FILELIST) $(VFLAGS)

run: compile
	@out="$$($(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'TESTBENCH PASSED'

clean:
	rm -rf $(OBJ_DIR)
